// File: flist.f
+incdir+rtl
rtl/fifo_pkg.sv
rtl/lane_wr_if.sv
rtl/gray_sync.sv
rtl/lane_ram.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/async_fifo_top.sv
verif/tb_async_fifo.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_async_fifo -f flist.f

out=$(./obj_dir/Vtb_async_fifo)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

// File: verif/tb_async_fifo.sv
// Dual-clock FIFO testbench
`timescale 1ns/10ps
`include "fifo_params.svh"

module tb_async_fifo
    import fifo_pkg::*;
();

    // Budget from writes and reads of all tests plus resets and idle waits
    localparam int TRANSFERS     = 160 + 120 + 131 + 512;
    localparam int SETTLE_CYCLES = 600;
    localparam int WATCHDOG_NS   = (TRANSFERS + SETTLE_CYCLES) * 40 * 4;
    localparam int DEPTH         = `FIFO_DEPTH;

    logic               clk_wr_i;
    logic               clk_rd_i;
    logic               reset;
    logic               wr_en_i;
    logic [`FIFO_DW-1:0] data_i;
    logic               rd_en_i;
    logic [`FIFO_DW-1:0] data_o;
    logic               bus_mode_i;
    logic               big_endian_i;
    logic [1:0]         fsel_i;
    logic               full_o;
    logic               empty_o;
    logic               almost_full_o;
    logic               almost_empty_o;
    logic               half_full_o;

    // Scoreboard state
    word_t   exp_q [$];
    string   test_name;
    int      errors;
    int      checks;
    int      rd_issued;
    logic    rd_pending;
    // Model of the captured config and a pending narrow half
    logic    cur_narrow;
    logic    cur_be;
    logic    have_half;
    word_t   first_half;

    async_fifo_top dut (
        .clk_wr_i       (clk_wr_i),
        .clk_rd_i       (clk_rd_i),
        .reset          (reset),
        .wr_en_i        (wr_en_i),
        .data_i         (data_i),
        .rd_en_i        (rd_en_i),
        .data_o         (data_o),
        .bus_mode_i     (bus_mode_i),
        .big_endian_i   (big_endian_i),
        .fsel_i         (fsel_i),
        .full_o         (full_o),
        .empty_o        (empty_o),
        .almost_full_o  (almost_full_o),
        .almost_empty_o (almost_empty_o),
        .half_full_o    (half_full_o)
    );

    // ------------------------------------------------------------
    // Clocks
    // ------------------------------------------------------------
    always #20 clk_rd_i = ~clk_rd_i;

    // Write clock trails the read clock by 13 ns
    always begin
        #13;
        forever #20 clk_wr_i = ~clk_wr_i;
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Stored word from one full write or two narrow halves
    function automatic word_t ref_word(input word_t first, input word_t second,
                                       input logic narrow, input logic be);
        if (!narrow) begin
            return be ? first : {first[8:0], first[17:9]};
        end
        // Big endian puts the first half on top
        return be ? {first[8:0], second[8:0]} : {second[8:0], first[8:0]};
    endfunction

    // Offset in words picked by fsel
    function automatic int ofs_for(input int fsel);
        case (fsel)
            0:       return `FIFO_OFS0;
            1:       return `FIFO_OFS1;
            2:       return `FIFO_OFS2;
            default: return `FIFO_OFS3;
        endcase
    endfunction

    // Queue the expected word once a write is accepted
    task automatic record_write(input word_t d);
        if (!cur_narrow) begin
            exp_q.push_back(ref_word(d, '0, 1'b0, cur_be));
        end else if (!have_half) begin
            first_half = d;
            have_half  = 1'b1;
        end else begin
            exp_q.push_back(ref_word(first_half, d, 1'b1, cur_be));
            have_half = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // Compare process
    // ------------------------------------------------------------
    // Read accepted at a rising edge is checked at the next falling edge
    always @(negedge clk_rd_i) begin
        if (rd_pending) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("%s: read returned %h with no word outstanding", test_name, data_o);
                errors++;
            end else if (data_o !== exp_q[0]) begin
                $display("FAIL %s: expected %h, actual %h", test_name, exp_q[0], data_o);
                errors++;
                void'(exp_q.pop_front());
            end else begin
                void'(exp_q.pop_front());
            end
        end
        rd_pending = rd_en_i && !empty_o && reset;
        if (rd_pending) begin
            rd_issued++;
        end
    end

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------
    // Config is set together with reset and held through capture
    task automatic apply_reset(input logic narrow, input logic be, input logic [1:0] fsel);
        @(posedge clk_rd_i);
        reset        <= 1'b0;
        wr_en_i      <= 1'b0;
        rd_en_i      <= 1'b0;
        bus_mode_i   <= narrow;
        big_endian_i <= be;
        fsel_i       <= fsel;
        cur_narrow = narrow;
        cur_be     = be;
        have_half  = 1'b0;
        exp_q.delete();
        repeat (5) @(posedge clk_rd_i);
        reset <= 1'b1;
        repeat (3) @(posedge clk_rd_i);
    endtask

    // One write attempt that reports acceptance in ok
    task automatic try_write(input word_t d, output logic ok);
        @(posedge clk_wr_i);
        wr_en_i <= 1'b1;
        data_i  <= d;
        @(negedge clk_wr_i);
        ok = !full_o;
        @(posedge clk_wr_i);
        wr_en_i <= 1'b0;
        if (ok) begin
            record_write(d);
        end
    endtask

    // Retries until accepted
    task automatic push_word(input word_t d);
        logic ok;
        ok = 1'b0;
        while (!ok) begin
            try_write(d, ok);
        end
    endtask

    task automatic write_random(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $urandom;
            push_word(r[`FIFO_DW-1:0]);
        end
    endtask

    // Holds rd_en until n reads have been accepted
    task automatic read_words(input int n);
        int target;
        target = rd_issued + n;
        @(posedge clk_rd_i);
        rd_en_i <= 1'b1;
        while (rd_issued < target) begin
            @(posedge clk_rd_i);
        end
        rd_en_i <= 1'b0;
        repeat (2) @(negedge clk_rd_i);
    endtask

    // All written words must have come back
    task automatic settle_check();
        repeat (4) @(negedge clk_rd_i);
        if (exp_q.size() != 0 || have_half) begin
            $display("%s: %0d written words were never read back", test_name, exp_q.size());
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s %s: expected %0b, actual %0b", test_name, name, exp, act);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, a handshake never completed");
        $display("TEST FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] r;
        logic        ok;
        int          accepted;
        int          ofs;
        int          filled;
        int          levels [8];
        word_t       held;
        r = $urandom(11);
        clk_rd_i     = 1'b0;
        clk_wr_i     = 1'b0;
        reset        = 1'b0;
        wr_en_i      = 1'b0;
        data_i       = '0;
        rd_en_i      = 1'b0;
        bus_mode_i   = 1'b0;
        big_endian_i = 1'b1;
        fsel_i       = 2'd0;
        errors       = 0;
        checks       = 0;
        rd_issued    = 0;
        rd_pending   = 1'b0;
        have_half    = 1'b0;

        // Equal width in both byte orders with concurrent traffic
        test_name = "equal_big_endian";
        apply_reset(BUS_EQUAL, 1'b1, 2'd0);
        fork
            write_random(40);
            read_words(40);
        join
        settle_check();
        test_name = "equal_little_endian";
        apply_reset(BUS_EQUAL, 1'b0, 2'd0);
        fork
            write_random(40);
            read_words(40);
        join
        settle_check();

        // Narrow writes with two halves per word
        test_name = "narrow_big_endian";
        apply_reset(BUS_NARROW_WR, 1'b1, 2'd0);
        fork
            write_random(40);
            read_words(20);
        join
        settle_check();
        test_name = "narrow_little_endian";
        apply_reset(BUS_NARROW_WR, 1'b0, 2'd0);
        fork
            write_random(40);
            read_words(20);
        join
        settle_check();

        // Overfill with no reads, then drain
        test_name = "full_backpressure";
        apply_reset(BUS_EQUAL, 1'b1, 2'd0);
        accepted = 0;
        for (int i = 0; i < DEPTH + 3; i++) begin
            r = $urandom;
            try_write(r[`FIFO_DW-1:0], ok);
            if (ok) begin
                accepted++;
            end
            if (i == DEPTH - 1) begin
                @(negedge clk_wr_i);
                check_flag("full_o after last free entry", 1'b1, full_o);
            end
        end
        checks++;
        if (accepted != DEPTH) begin
            $display("FAIL %s: expected %0d, actual %0d", test_name, DEPTH, accepted);
            errors++;
        end
        read_words(DEPTH);
        check_flag("empty_o after drain", 1'b1, empty_o);
        // Read while empty leaves the output alone
        held = data_o;
        @(posedge clk_rd_i);
        rd_en_i <= 1'b1;
        @(posedge clk_rd_i);
        rd_en_i <= 1'b0;
        repeat (2) @(negedge clk_rd_i);
        checks++;
        if (data_o !== held) begin
            $display("FAIL %s read while empty: expected %h, actual %h",
                     test_name, held, data_o);
            errors++;
        end
        settle_check();

        // Flag thresholds for every offset
        for (int f = 0; f < 4; f++) begin
            test_name = $sformatf("flags_fsel%0d", f);
            apply_reset(BUS_EQUAL, 1'b1, f[1:0]);
            ofs    = ofs_for(f);
            filled = 0;
            levels = '{0, ofs, ofs + 1, DEPTH / 2, DEPTH / 2 + 1,
                       DEPTH - ofs - 1, DEPTH - ofs, DEPTH};
            for (int l = 0; l < 8; l++) begin
                while (filled < levels[l]) begin
                    r = $urandom;
                    push_word(r[`FIFO_DW-1:0]);
                    filled++;
                end
                // Let both synchronizers catch up
                fork
                    repeat (10) @(posedge clk_wr_i);
                    repeat (10) @(posedge clk_rd_i);
                join
                @(negedge clk_rd_i);
                check_flag($sformatf("fill %0d almost_full_o", filled),
                           filled >= DEPTH - ofs, almost_full_o);
                check_flag($sformatf("fill %0d half_full_o", filled),
                           filled >= DEPTH / 2 + 1, half_full_o);
                check_flag($sformatf("fill %0d almost_empty_o", filled),
                           filled <= ofs, almost_empty_o);
            end
            read_words(filled);
            settle_check();
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/async_fifo_top.sv
// Dual-clock FIFO top level
`timescale 1ns/10ps
`include "fifo_params.svh"

module async_fifo_top
    import fifo_pkg::*;
(
    input  logic                clk_wr_i,
    input  logic                clk_rd_i,
    input  logic                reset,
    // Write side
    input  logic                wr_en_i,
    input  logic [`FIFO_DW-1:0] data_i,
    // Read side
    input  logic                rd_en_i,
    output logic [`FIFO_DW-1:0] data_o,
    // Config sampled once after reset
    input  logic                bus_mode_i,
    input  logic                big_endian_i,
    input  logic [1:0]          fsel_i,
    // Status
    output logic                full_o,
    output logic                empty_o,
    output logic                almost_full_o,
    output logic                almost_empty_o,
    output logic                half_full_o
);

    // Cross-domain pointers
    ptr_t                    wr_gray;
    ptr_t                    rd_gray;
    fifo_cfg_t               cfg;
    // Read bus to the lanes
    logic [`FIFO_AW-1:0]     rd_addr;
    logic                    rd_en;
    half_t [`FIFO_LANES-1:0] rd_data;

    lane_wr_if lw ();

    // ------------------------------------------------------------
    // Write domain
    // ------------------------------------------------------------
    fifo_wr_ctrl u_wr_ctrl (
        .clk_wr_i      (clk_wr_i),
        .reset         (reset),
        .wr_en_i       (wr_en_i),
        .data_i        (data_i),
        .bus_mode_i    (bus_mode_i),
        .big_endian_i  (big_endian_i),
        .fsel_i        (fsel_i),
        .rd_gray_i     (rd_gray),
        .full_o        (full_o),
        .almost_full_o (almost_full_o),
        .half_full_o   (half_full_o),
        .wr_gray_o     (wr_gray),
        .cfg_o         (cfg),
        .lw            (lw.wr_side)
    );

    // ------------------------------------------------------------
    // Storage lanes
    // ------------------------------------------------------------
    for (genvar i = 0; i < `FIFO_LANES; i++) begin : g_lane
        lane_ram #(
            .LANE (i)
        ) u_lane (
            .clk_rd_i  (clk_rd_i),
            .reset     (reset),
            .rd_addr_i (rd_addr),
            .rd_en_i   (rd_en),
            .rd_data_o (rd_data[i]),
            .lw        (lw.lane_side)
        );
    end

    // ------------------------------------------------------------
    // Read domain
    // ------------------------------------------------------------
    fifo_rd_ctrl u_rd_ctrl (
        .clk_rd_i       (clk_rd_i),
        .reset          (reset),
        .rd_en_i        (rd_en_i),
        .cfg_i          (cfg),
        .wr_gray_i      (wr_gray),
        .rd_data_i      (rd_data),
        .empty_o        (empty_o),
        .almost_empty_o (almost_empty_o),
        .rd_addr_o      (rd_addr),
        .rd_en_o        (rd_en),
        .rd_gray_o      (rd_gray),
        .data_o         (data_o)
    );

endmodule

// File: rtl/fifo_rd_ctrl.sv
// FIFO read controller
`timescale 1ns/10ps
`include "fifo_params.svh"

module fifo_rd_ctrl
    import fifo_pkg::*;
(
    input  logic                    clk_rd_i,
    input  logic                    reset,
    input  logic                    rd_en_i,
    input  fifo_cfg_t               cfg_i,
    input  ptr_t                    wr_gray_i,
    input  half_t [`FIFO_LANES-1:0] rd_data_i,
    output logic                    empty_o,
    output logic                    almost_empty_o,
    output logic [`FIFO_AW-1:0]     rd_addr_o,
    output logic                    rd_en_o,
    output ptr_t                    rd_gray_o,
    output word_t                   data_o
);

    // Read pointer state
    ptr_t  rd_bin;
    ptr_t  rd_bin_next;
    // Write pointer as seen here
    ptr_t  wr_bin_sync;
    logic  rd_accept;
    fill_t fill_next;

    // ------------------------------------------------------------
    // Read pointer
    // ------------------------------------------------------------
    // Reads while empty are dropped here
    assign rd_accept   = rd_en_i & ~empty_o;
    assign rd_bin_next = rd_bin + ptr_t'(rd_accept);

    always_ff @(posedge clk_rd_i or negedge reset) begin
        if (!reset) begin
            rd_bin    <= '0;
            rd_gray_o <= '0;
        end else begin
            rd_bin    <= rd_bin_next;
            // Registered Gray copy for the write domain
            rd_gray_o <= bin2gray(rd_bin_next);
        end
    end

    // Lanes register their entry on the accepting edge
    assign rd_addr_o = rd_bin[`FIFO_AW-1:0];
    assign rd_en_o   = rd_accept;

    // ------------------------------------------------------------
    // Output word
    // ------------------------------------------------------------
    // Lane 0 on top of lane 1
    // Endianness was already applied on the write side
    assign data_o = {rd_data_i[0], rd_data_i[1]};

    // ------------------------------------------------------------
    // Read-side flags
    // ------------------------------------------------------------
    gray_sync u_wr_sync (
        .clk_i  (clk_rd_i),
        .reset  (reset),
        .gray_i (wr_gray_i),
        .bin_o  (wr_bin_sync)
    );

    // Fill after this edge's read
    // Write side may be ahead but never behind
    assign fill_next = fill_t'(wr_bin_sync - rd_bin_next);

    // FIFO starts empty out of reset
    always_ff @(posedge clk_rd_i or negedge reset) begin
        if (!reset) begin
            empty_o        <= 1'b1;
            almost_empty_o <= 1'b1;
        end else begin
            empty_o        <= (fill_next == '0);
            // Offset is fixed long before reads start
            almost_empty_o <= (fill_next <= cfg_i.ofs);
        end
    end

endmodule

// File: rtl/fifo_wr_ctrl.sv
// FIFO write controller
`timescale 1ns/10ps
`include "fifo_params.svh"

module fifo_wr_ctrl
    import fifo_pkg::*;
(
    input  logic       clk_wr_i,
    input  logic       reset,
    input  logic       wr_en_i,
    input  word_t      data_i,
    input  logic       bus_mode_i,
    input  logic       big_endian_i,
    input  logic [1:0] fsel_i,
    input  ptr_t       rd_gray_i,
    output logic       full_o,
    output logic       almost_full_o,
    output logic       half_full_o,
    output ptr_t       wr_gray_o,
    output fifo_cfg_t  cfg_o,
    lane_wr_if.wr_side lw
);

    localparam fill_t DEPTH_FILL = fill_t'(`FIFO_DEPTH);
    localparam fill_t HALF_FILL  = fill_t'(`FIFO_DEPTH / 2 + 1);

    // Config
    fifo_cfg_t cfg_in;
    fifo_cfg_t cfg_cur;
    logic      cfg_done;
    // Pointers and phase
    ptr_t      wr_bin;
    ptr_t      wr_bin_next;
    ptr_t      rd_bin_sync;
    wr_phase_e phase;
    logic      wr_accept;
    logic      word_done;
    logic      first_lane;
    fill_t     fill_next;

    // ------------------------------------------------------------
    // Config capture
    // ------------------------------------------------------------
    // Offset lookup from the select pins
    always_comb begin
        cfg_in.bus_mode   = bus_mode_e'(bus_mode_i);
        cfg_in.big_endian = big_endian_i;
        case (fsel_i)
            2'd0:    cfg_in.ofs = fill_t'(`FIFO_OFS0);
            2'd1:    cfg_in.ofs = fill_t'(`FIFO_OFS1);
            2'd2:    cfg_in.ofs = fill_t'(`FIFO_OFS2);
            default: cfg_in.ofs = fill_t'(`FIFO_OFS3);
        endcase
    end

    // Latched on the first edge after reset and then frozen
    always_ff @(posedge clk_wr_i or negedge reset) begin
        if (!reset) begin
            cfg_o    <= '0;
            cfg_done <= 1'b0;
        end else if (!cfg_done) begin
            cfg_o    <= cfg_in;
            cfg_done <= 1'b1;
        end
    end

    // Pins still count during the capture edge itself
    assign cfg_cur = cfg_done ? cfg_o : cfg_in;

    // ------------------------------------------------------------
    // Pointer and half-word phase
    // ------------------------------------------------------------
    assign wr_accept = wr_en_i & ~full_o;
    // Narrow words count only once the second half lands
    assign word_done = wr_accept &
                       ((cfg_cur.bus_mode == BUS_EQUAL) || (phase == PHASE_SECOND));
    assign wr_bin_next = wr_bin + ptr_t'(word_done);

    always_ff @(posedge clk_wr_i or negedge reset) begin
        if (!reset) begin
            wr_bin    <= '0;
            wr_gray_o <= '0;
            phase     <= PHASE_FIRST;
        end else begin
            wr_bin    <= wr_bin_next;
            wr_gray_o <= bin2gray(wr_bin_next);
            if (wr_accept && cfg_cur.bus_mode == BUS_NARROW_WR) begin
                phase <= (phase == PHASE_FIRST) ? PHASE_SECOND : PHASE_FIRST;
            end
        end
    end

    // ------------------------------------------------------------
    // Lane steering
    // ------------------------------------------------------------
    // Big endian starts a narrow word in the upper lane
    assign first_lane = ~cfg_cur.big_endian;
    assign lw.clk     = clk_wr_i;
    assign lw.addr    = wr_bin[`FIFO_AW-1:0];

    always_comb begin
        lw.we = '0;
        if (cfg_cur.bus_mode == BUS_NARROW_WR) begin
            // Same half word to both lanes with one strobe
            lw.data[0] = data_i[`FIFO_HW-1:0];
            lw.data[1] = data_i[`FIFO_HW-1:0];
            lw.we[first_lane ^ (phase == PHASE_SECOND)] = wr_accept;
        end else begin
            // Little endian swaps the two halves
            if (cfg_cur.big_endian) begin
                lw.data[0] = data_i[`FIFO_DW-1:`FIFO_HW];
                lw.data[1] = data_i[`FIFO_HW-1:0];
            end else begin
                lw.data[0] = data_i[`FIFO_HW-1:0];
                lw.data[1] = data_i[`FIFO_DW-1:`FIFO_HW];
            end
            lw.we = {`FIFO_LANES{wr_accept}};
        end
    end

    // ------------------------------------------------------------
    // Write-side flags
    // ------------------------------------------------------------
    gray_sync u_rd_sync (
        .clk_i  (clk_wr_i),
        .reset  (reset),
        .gray_i (rd_gray_i),
        .bin_o  (rd_bin_sync)
    );

    // Fill after this edge against the lagging read pointer
    assign fill_next = fill_t'(wr_bin_next - rd_bin_sync);

    always_ff @(posedge clk_wr_i or negedge reset) begin
        if (!reset) begin
            full_o        <= 1'b0;
            almost_full_o <= 1'b0;
            half_full_o   <= 1'b0;
        end else begin
            full_o        <= (fill_next == DEPTH_FILL);
            almost_full_o <= (fill_next >= fill_t'(DEPTH_FILL - cfg_cur.ofs));
            half_full_o   <= (fill_next >= HALF_FILL);
        end
    end

endmodule

// File: rtl/lane_ram.sv
// Half-width storage bank
`timescale 1ns/10ps
`include "fifo_params.svh"

module lane_ram
    import fifo_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic                clk_rd_i,
    input  logic                reset,
    input  logic [`FIFO_AW-1:0] rd_addr_i,
    input  logic                rd_en_i,
    output half_t               rd_data_o,
    lane_wr_if.lane_side        lw
);

    // One half word per FIFO entry
    half_t mem [`FIFO_DEPTH];

    // ------------------------------------------------------------
    // Write port on the write clock
    // ------------------------------------------------------------
    always_ff @(posedge lw.clk) begin
        if (lw.we[LANE]) begin
            mem[lw.addr] <= lw.data[LANE];
        end
    end

    // ------------------------------------------------------------
    // Read port on the read clock
    // ------------------------------------------------------------
    // Output register holds until the next accepted read
    always_ff @(posedge clk_rd_i or negedge reset) begin
        if (!reset) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: rtl/gray_sync.sv
// Gray pointer synchronizer
`timescale 1ns/10ps

module gray_sync
    import fifo_pkg::*;
(
    input  logic clk_i,
    input  logic reset,
    input  ptr_t gray_i,
    output ptr_t bin_o
);

    // Two-stage capture in the destination domain
    ptr_t sync_q1;
    ptr_t sync_q2;

    // ------------------------------------------------------------
    // Double flop
    // ------------------------------------------------------------
    // Gray input changes one bit at a time
    // so a late sample is off by one step at most
    always_ff @(posedge clk_i or negedge reset) begin
        if (!reset) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gray_i;
            sync_q2 <= sync_q1;
        end
    end

    // ------------------------------------------------------------
    // Gray to binary
    // ------------------------------------------------------------
    // Each binary bit is the XOR of all Gray bits at or above it
    always_comb begin
        for (int i = 0; i < $bits(ptr_t); i++) begin
            bin_o[i] = ^(sync_q2 >> i);
        end
    end

endmodule

// File: rtl/lane_wr_if.sv
// Lane write bus
`timescale 1ns/10ps
`include "fifo_params.svh"

interface lane_wr_if;

    // Write clock forwarded by the write controller
    logic clk;
    // Shared entry address for every lane
    logic [`FIFO_AW-1:0]                  addr;
    // One half word per lane
    logic [`FIFO_LANES-1:0][`FIFO_HW-1:0] data;
    // Per-lane write strobes
    logic [`FIFO_LANES-1:0]               we;

    // ------------------------------------------------------------
    // Views
    // ------------------------------------------------------------
    // Controller side drives everything
    modport wr_side (
        output clk,
        output addr,
        output data,
        output we
    );

    // Each bank picks out its own slice
    modport lane_side (
        input  clk,
        input  addr,
        input  data,
        input  we
    );

endinterface

// File: rtl/fifo_pkg.sv
// FIFO shared types
`include "fifo_params.svh"

package fifo_pkg;

    // Pointer carries one wrap bit above the address
    typedef logic [`FIFO_AW:0]   ptr_t;
    typedef logic [`FIFO_DW-1:0] word_t;
    typedef logic [`FIFO_HW-1:0] half_t;
    // Fill count wide enough to hold FIFO_DEPTH itself
    typedef logic [`FIFO_AW:0]   fill_t;

    // Write bus width relative to the read bus
    typedef enum logic {
        BUS_EQUAL     = 1'b0,
        BUS_NARROW_WR = 1'b1
    } bus_mode_e;

    // Which half of a narrow word is expected next
    typedef enum logic {
        PHASE_FIRST  = 1'b0,
        PHASE_SECOND = 1'b1
    } wr_phase_e;

    // Settings captured once after reset
    typedef struct packed {
        bus_mode_e bus_mode;
        logic      big_endian;
        fill_t     ofs;
    } fifo_cfg_t;

    // Binary to Gray for both pointer owners
    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

endpackage

// File: rtl/fifo_params.svh
// FIFO sizing and flag offsets
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// ------------------------------------------------------------
// Storage geometry
// ------------------------------------------------------------
// Power-of-two count of full words held
`define FIFO_DEPTH 64
// Address bits for FIFO_DEPTH entries
`define FIFO_AW    6
// Full word and half word widths
`define FIFO_DW    18
`define FIFO_HW    9
// Half-width banks with lane 0 as the upper half
`define FIFO_LANES 2

// ------------------------------------------------------------
// Almost-flag offsets in full words
// ------------------------------------------------------------
// Picked by fsel_i at config capture
`define FIFO_OFS0  2
`define FIFO_OFS1  4
`define FIFO_OFS2  8
`define FIFO_OFS3  16

`endif
